// ==== arbiter_checker.sv ====
// Arbiter response checker

`default_nettype none

`include "arbiter_consts.svh"

module arbiter_checker
	import arbiter_pkg::*;
(
	input  logic                   clock,
	input  logic                   rstn,
	input  logic [`NUM_CU-1:0]     cu_enable,
	input  logic [`NUM_CU-1:0]     exp_mask,
	input  logic                   mask_check,
	input  read_cmd_t              cu_cmd [`NUM_CU],
	input  logic [`NUM_CU-1:0]     cu_cmd_valid,
	input  logic [`NUM_CU-1:0]     cu_cmd_ready,
	input  read_cmd_t              mem_cmd,
	input  logic                   mem_cmd_valid,
	input  logic                   mem_cmd_ready,
	input  logic                   fair_check,
	input  read_resp_t             mem_resp,
	input  logic                   mem_resp_valid,
	input  read_resp_t             cu_resp [`NUM_CU],
	input  logic [`NUM_CU-1:0]     cu_resp_valid,
	input  logic [`COUNT_BITS-1:0] counts_sum,
	input  logic [`COUNT_BITS-1:0] vertex_done_total,
	output int                     error_count,
	output int                     check_count,
	output int                     full_cycles
);

	int                     errors = 0;
	int                     checks = 0;
	int                     fulls = 0;
	read_cmd_t              exp_q [$];
	read_cmd_t              exp_cmd;
	logic                   exp_head;
	logic [`NUM_CU-1:0]     exp_valid;
	logic [`COUNT_BITS-1:0] sum_d1;
	logic [`COUNT_BITS-1:0] sum_d2;
	logic                   resp_d_valid;
	read_resp_t             resp_d;
	logic                   fair_seen;
	logic [`CU_ID_BITS-1:0] fair_last;

	assign error_count = errors;
	assign check_count = checks;
	assign full_cycles = fulls;

	task automatic value_error(input string test, input logic [63:0] expected,
			input logic [63:0] actual);
		$display("** Error %s: expected %h actual %h", test, expected, actual);
		errors++;
	endtask

	// Next enabled CU after the last winner with wrap
	function automatic logic [`CU_ID_BITS-1:0] next_id(input logic [`CU_ID_BITS-1:0] last,
			input logic [`NUM_CU-1:0] mask);
		logic [`CU_ID_BITS-1:0] idx;
		for (int off = 1; off <= `NUM_CU; off++) begin
			idx = `CU_ID_BITS'((int'(last) + off) % `NUM_CU);
			if (mask[idx]) return idx;
		end
		return last;
	endfunction

	always @(posedge clock) begin
		if (!rstn) begin
			exp_q.delete();
			sum_d1       = '0;
			sum_d2       = '0;
			resp_d_valid = 1'b0;
			fair_seen    = 1'b0;
		end else begin
			if (mask_check) begin
				checks++;
				if (cu_enable !== exp_mask) begin
					value_error("config mask", 64'(exp_mask), 64'(cu_enable));
				end
			end
			// Queue depth equals buffer occupancy
			if (exp_q.size() >= `CMD_FIFO_DEPTH) begin
				fulls++;
				if (cu_cmd_ready != '0) begin
					$display("Error: a CU was granted while the command buffer was full");
					errors++;
				end
			end
			// Head is valid exactly while a command is pending
			exp_head = (exp_q.size() != 0);
			checks++;
			if (mem_cmd_valid !== exp_head) begin
				value_error("command valid", 64'(exp_head), 64'(mem_cmd_valid));
			end
			// Pops come before this edge's accepts are queued
			if (mem_cmd_valid && mem_cmd_ready && exp_head) begin
				checks++;
				exp_cmd = exp_q.pop_front();
				if (mem_cmd !== exp_cmd) value_error("delivery", 64'(exp_cmd), 64'(mem_cmd));
				if (fair_check) begin
					if (fair_seen && mem_cmd.id != next_id(fair_last, exp_mask)) begin
						value_error("fairness", 64'(next_id(fair_last, exp_mask)),
							64'(mem_cmd.id));
					end
					fair_last = mem_cmd.id;
					fair_seen = 1'b1;
				end
			end
			if (!fair_check) fair_seen = 1'b0;
			for (int i = 0; i < `NUM_CU; i++) begin
				if (cu_cmd_valid[i] && cu_cmd_ready[i]) begin
					exp_cmd    = cu_cmd[i];
					exp_cmd.id = `CU_ID_BITS'(i);
					exp_q.push_back(exp_cmd);
				end
			end
			// Response seen last edge shows up now
			exp_valid = resp_d_valid ? (`NUM_CU'(1) << resp_d.id) : '0;
			checks++;
			if (cu_resp_valid !== exp_valid) begin
				value_error("response valid", 64'(exp_valid), 64'(cu_resp_valid));
			end else if (resp_d_valid && cu_resp[resp_d.id] !== resp_d) begin
				value_error("response data", 64'(resp_d), 64'(cu_resp[resp_d.id]));
			end
			resp_d_valid = mem_resp_valid;
			resp_d       = mem_resp;
			checks++;
			if (vertex_done_total !== sum_d2) begin
				value_error("done sum", 64'(sum_d2), 64'(vertex_done_total));
			end
			sum_d2 = sum_d1;
			sum_d1 = counts_sum;
		end
	end

endmodule

`default_nettype wire

// ==== arbiter_consts.svh ====
// Arbiter shared constants

`ifndef ARBITER_CONSTS_SVH
`define ARBITER_CONSTS_SVH

// Compute unit count and id width
`define NUM_CU 4
`define CU_ID_BITS 2

// Memory side widths
`define ADDR_BITS 32
`define DATA_BITS 32

// Burst command buffer entries, power of two
`define CMD_FIFO_DEPTH 8

// Per-CU vertex counter width
`define COUNT_BITS 16

`endif

// ==== arbiter_ctrl_fsm.sv ====
// Start-up controller

`default_nettype none

`include "arbiter_consts.svh"

module arbiter_ctrl_fsm
	import arbiter_pkg::*;
(
	input  logic               clock,
	input  logic               rstn,
	input  logic               enabled_in,
	input  cu_config_t         cu_config,
	output logic [`NUM_CU-1:0] cu_enable,
	output logic               enabled
);

	ctrl_state_t        state;
	cu_config_t         config_q;
	logic               config_nz;
	logic [`NUM_CU-1:0] mask;

	assign config_nz = (cu_config.active_cu_count != '0);

	// Thermometer mask from the latched count
	always_comb begin
		for (int i = 0; i < `NUM_CU; i++) begin
			mask[i] = (32'(i) < config_q.active_cu_count);
		end
	end

	//////////////////////////////
	// State and enable register
	//////////////////////////////

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			enabled   <= 1'b0;
			state     <= IDLE;
			config_q  <= '0;
			cu_enable <= '0;
		end else begin
			enabled   <= enabled_in;
			cu_enable <= (state == RUN && enabled) ? mask : '0;
			case (state)
				IDLE: begin
					if (enabled && config_nz) begin
						config_q <= cu_config;
						state    <= CONFIG;
					end
				end
				CONFIG: begin
					state <= enabled ? RUN : IDLE;
				end
				RUN: begin
					if (!enabled) begin
						state <= IDLE;
					end else if (config_nz) begin
						// Reconfigure on the fly, mask follows next cycle
						config_q <= cu_config;
					end
				end
				default: begin
					state <= IDLE;
				end
			endcase
		end
	end

endmodule

`default_nettype wire

// ==== arbiter_pkg.sv ====
// Arbiter types

`default_nettype none

`include "arbiter_consts.svh"

package arbiter_pkg;

	// Read command from a CU, id stamped by the arbiter
	typedef struct packed {
		logic [`CU_ID_BITS-1:0] id;
		logic [`ADDR_BITS-1:0]  addr;
		logic [3:0]             burst_size;
	} read_cmd_t;

	// Memory response routed back by id
	typedef struct packed {
		logic [`CU_ID_BITS-1:0] id;
		logic [`DATA_BITS-1:0]  data;
	} read_resp_t;

	// Configuration word, mode flags are carried only
	typedef struct packed {
		logic [31:0] mode_flags;
		logic [31:0] active_cu_count;
	} cu_config_t;

	typedef enum logic [1:0] {IDLE, CONFIG, RUN} ctrl_state_t;

endpackage

`default_nettype wire

// ==== arbiter_properties.sv ====
// Arbiter protocol assertions

`default_nettype none

`include "arbiter_consts.svh"

module arbiter_properties
	import arbiter_pkg::*;
(
	input logic               clock,
	input logic               rstn,
	input logic [`NUM_CU-1:0] cu_enable,
	input logic [`NUM_CU-1:0] cu_cmd_ready,
	input read_cmd_t          mem_cmd,
	input logic               mem_cmd_valid,
	input logic               mem_cmd_ready,
	input logic [`NUM_CU-1:0] cu_resp_valid
);

	single_grant: assert property (@(posedge clock) disable iff (!rstn)
		$onehot0(cu_cmd_ready)) else $error("More than one CU ready in one cycle");

	grant_enabled_only: assert property (@(posedge clock) disable iff (!rstn)
		(cu_cmd_ready & ~cu_enable) == '0) else $error("Ready given to a disabled CU");

	// Held command must not change before the memory side takes it
	mem_cmd_hold: assert property (@(posedge clock) disable iff (!rstn)
		mem_cmd_valid && !mem_cmd_ready |=> mem_cmd_valid && $stable(mem_cmd))
		else $error("Memory command changed while stalled");

	resp_one_hot: assert property (@(posedge clock) disable iff (!rstn)
		$onehot0(cu_resp_valid)) else $error("Response valid on several CUs");

endmodule

bind pagerank_arbiter_top arbiter_properties arbiter_properties_inst (
	.clock         (clock),
	.rstn          (rstn),
	.cu_enable     (cu_enable),
	.cu_cmd_ready  (cu_cmd_ready),
	.mem_cmd       (mem_cmd),
	.mem_cmd_valid (mem_cmd_valid),
	.mem_cmd_ready (mem_cmd_ready),
	.cu_resp_valid (cu_resp_valid)
);

`default_nettype wire

// ==== burst_cmd_fifo.sv ====
// Burst command buffer

`default_nettype none

`include "arbiter_consts.svh"

module burst_cmd_fifo
	import arbiter_pkg::*;
#(
	parameter int DEPTH = `CMD_FIFO_DEPTH
) (
	input  logic      clock,
	input  logic      rstn,
	input  logic      push,
	input  read_cmd_t push_cmd,
	input  logic      pop_ready,
	output logic      full,
	output logic      head_valid,
	output read_cmd_t head_cmd
);

	localparam int PTR_BITS = $clog2(DEPTH);
	localparam int CNT_BITS = PTR_BITS + 1;

	read_cmd_t           mem [DEPTH];
	logic [PTR_BITS-1:0] wr_ptr;
	logic [PTR_BITS-1:0] rd_ptr;
	logic [CNT_BITS-1:0] count;
	logic                do_push;
	logic                do_pop;

	assign full       = (count == CNT_BITS'(DEPTH));
	assign head_valid = (count != '0);
	// Show-ahead head entry
	assign head_cmd   = mem[rd_ptr];

	assign do_push = push && !full;
	assign do_pop  = pop_ready && head_valid;

	always_ff @(posedge clock) begin
		if (do_push) begin
			mem[wr_ptr] <= push_cmd;
		end
	end

	// Pointers wrap on their own width
	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
		end else begin
			if (do_push) begin
				wr_ptr <= wr_ptr + 1'b1;
			end
			if (do_pop) begin
				rd_ptr <= rd_ptr + 1'b1;
			end
			case ({do_push, do_pop})
				2'b10:   count <= count + 1'b1;
				2'b01:   count <= count - 1'b1;
				default: count <= count;
			endcase
		end
	end

endmodule

`default_nettype wire

// ==== flist.f ====
+incdir+.
arbiter_pkg.sv
arbiter_ctrl_fsm.sv
read_cmd_arbiter.sv
burst_cmd_fifo.sv
read_resp_router.sv
vertex_done_sum.sv
pagerank_arbiter_top.sv
arbiter_properties.sv
arbiter_checker.sv
tb_pagerank_arbiter.sv

// ==== pagerank_arbiter_top.sv ====
// PageRank read arbiter top

`default_nettype none

`include "arbiter_consts.svh"

module pagerank_arbiter_top
	import arbiter_pkg::*;
(
	input  logic                   clock,
	input  logic                   rstn,

	// Start-up control
	input  logic                   enabled_in,
	input  cu_config_t             cu_config,
	output logic [`NUM_CU-1:0]     cu_enable,

	// CU read commands
	input  read_cmd_t              cu_cmd [`NUM_CU],
	input  logic [`NUM_CU-1:0]     cu_cmd_valid,
	output logic [`NUM_CU-1:0]     cu_cmd_ready,

	// Memory command port
	output read_cmd_t              mem_cmd,
	output logic                   mem_cmd_valid,
	input  logic                   mem_cmd_ready,

	// Memory responses and per-CU copies
	input  read_resp_t             mem_resp,
	input  logic                   mem_resp_valid,
	output read_resp_t             cu_resp [`NUM_CU],
	output logic [`NUM_CU-1:0]     cu_resp_valid,

	// Done counters
	input  logic [`COUNT_BITS-1:0] cu_vertex_count [`NUM_CU],
	output logic [`COUNT_BITS-1:0] vertex_done_total
);

	logic      enabled;
	logic      full;
	logic      push;
	read_cmd_t push_cmd;

	//////////////////////////////
	// Control
	//////////////////////////////

	arbiter_ctrl_fsm arbiter_ctrl_fsm_inst (
		.clock      (clock),
		.rstn       (rstn),
		.enabled_in (enabled_in),
		.cu_config  (cu_config),
		.cu_enable  (cu_enable),
		.enabled    (enabled)
	);

	//////////////////////////////
	// Command path
	//////////////////////////////

	read_cmd_arbiter read_cmd_arbiter_inst (
		.clock        (clock),
		.rstn         (rstn),
		.enabled      (enabled),
		.cu_enable    (cu_enable),
		.cu_cmd       (cu_cmd),
		.cu_cmd_valid (cu_cmd_valid),
		.full         (full),
		.cu_cmd_ready (cu_cmd_ready),
		.push         (push),
		.push_cmd     (push_cmd)
	);

	burst_cmd_fifo #(
		.DEPTH (`CMD_FIFO_DEPTH)
	) burst_cmd_fifo_inst (
		.clock      (clock),
		.rstn       (rstn),
		.push       (push),
		.push_cmd   (push_cmd),
		.pop_ready  (mem_cmd_ready),
		.full       (full),
		.head_valid (mem_cmd_valid),
		.head_cmd   (mem_cmd)
	);

	//////////////////////////////
	// Response path and done sum
	//////////////////////////////

	read_resp_router read_resp_router_inst (
		.clock          (clock),
		.rstn           (rstn),
		.enabled        (enabled),
		.mem_resp       (mem_resp),
		.mem_resp_valid (mem_resp_valid),
		.cu_resp        (cu_resp),
		.cu_resp_valid  (cu_resp_valid)
	);

	vertex_done_sum vertex_done_sum_inst (
		.clock             (clock),
		.rstn              (rstn),
		.cu_vertex_count   (cu_vertex_count),
		.vertex_done_total (vertex_done_total)
	);

endmodule

`default_nettype wire

// ==== read_cmd_arbiter.sv ====
// Round-robin read command arbiter

`default_nettype none

`include "arbiter_consts.svh"

module read_cmd_arbiter
	import arbiter_pkg::*;
(
	input  logic               clock,
	input  logic               rstn,
	input  logic               enabled,
	input  logic [`NUM_CU-1:0] cu_enable,
	input  read_cmd_t          cu_cmd [`NUM_CU],
	input  logic [`NUM_CU-1:0] cu_cmd_valid,
	input  logic               full,
	output logic [`NUM_CU-1:0] cu_cmd_ready,
	output logic               push,
	output read_cmd_t          push_cmd
);

	logic [`NUM_CU-1:0]     request;
	logic [`CU_ID_BITS-1:0] last_winner;
	logic [`CU_ID_BITS-1:0] winner;
	logic                   found;
	logic                   grant_ok;

	// Only enabled CUs take part
	assign request = enabled ? (cu_cmd_valid & cu_enable) : '0;

	//////////////////////////////
	// Wrapping priority search
	//////////////////////////////

	// Start just past the last winner
	always_comb begin
		winner = last_winner;
		found  = 1'b0;
		for (int off = 1; off <= `NUM_CU; off++) begin
			if (!found && request[(int'(last_winner) + off) % `NUM_CU]) begin
				winner = `CU_ID_BITS'((int'(last_winner) + off) % `NUM_CU);
				found  = 1'b1;
			end
		end
	end

	// Hold off while the buffer is full
	assign grant_ok = found && !full;
	assign push     = grant_ok;

	always_comb begin
		cu_cmd_ready = '0;
		if (grant_ok) begin
			cu_cmd_ready[winner] = 1'b1;
		end
	end

	// Stamp the winner's index over the incoming id
	always_comb begin
		push_cmd    = cu_cmd[winner];
		push_cmd.id = winner;
	end

	// Last winner, CU 0 goes first after reset
	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			last_winner <= `CU_ID_BITS'(`NUM_CU - 1);
		end else if (push) begin
			last_winner <= winner;
		end
	end

endmodule

`default_nettype wire

// ==== read_resp_router.sv ====
// Read response router

`default_nettype none

`include "arbiter_consts.svh"

module read_resp_router
	import arbiter_pkg::*;
(
	input  logic               clock,
	input  logic               rstn,
	input  logic               enabled,
	input  read_resp_t         mem_resp,
	input  logic               mem_resp_valid,
	output read_resp_t         cu_resp [`NUM_CU],
	output logic [`NUM_CU-1:0] cu_resp_valid
);

	logic [`NUM_CU-1:0] resp_sel;

	// One-hot decode of the response id
	always_comb begin
		for (int i = 0; i < `NUM_CU; i++) begin
			resp_sel[i] = enabled && mem_resp_valid && (mem_resp.id == `CU_ID_BITS'(i));
		end
	end

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			cu_resp_valid <= '0;
		end else begin
			cu_resp_valid <= resp_sel;
		end
	end

	// Only the selected slot takes the payload
	always_ff @(posedge clock) begin
		for (int i = 0; i < `NUM_CU; i++) begin
			if (resp_sel[i]) begin
				cu_resp[i] <= mem_resp;
			end
		end
	end

endmodule

`default_nettype wire

// ==== run.sh ====
#!/usr/bin/env bash
# Build with Verilator, run, and scan the log for the failure line
set -o pipefail
cd "$(dirname "$0")" \
	&& verilator --binary --timing --assert -f flist.f --top-module tb_pagerank_arbiter -o tb_sim \
	&& ./obj_dir/tb_sim 2>&1 | tee sim.log \
	&& ! grep -q "tests failed" sim.log \
	&& echo "PASS" \
	|| { echo "FAIL"; exit 1; }

// ==== tb_pagerank_arbiter.sv ====
// PageRank arbiter testbench

`default_nettype none

`include "arbiter_consts.svh"

module tb_pagerank_arbiter
	import arbiter_pkg::*;
();

	localparam int DELIVERY = 200;
	localparam int STALL = 40;
	localparam int RELEASE = 150;
	localparam int FAIR = 60;
	localparam int RESP = 60;
	// Phases plus the config waits, with margin for the drains
	localparam int RUN_LIMIT = 3 + 3 * 5 + DELIVERY + STALL + RELEASE + FAIR + 4 + RESP + 3 + 200;

	logic clock, rstn, enabled_in, mem_cmd_valid, mem_cmd_ready, mem_resp_valid;
	cu_config_t cu_config;
	read_cmd_t cu_cmd [`NUM_CU];
	read_cmd_t mem_cmd;
	read_resp_t mem_resp;
	read_resp_t cu_resp [`NUM_CU];
	logic [`NUM_CU-1:0] cu_enable, cu_cmd_valid, cu_cmd_ready, cu_resp_valid;
	logic [`COUNT_BITS-1:0] cu_vertex_count [`NUM_CU];
	logic [`COUNT_BITS-1:0] vertex_done_total, counts_sum;
	logic [`NUM_CU-1:0] accepted, cur_mask, exp_mask;
	logic mask_check, fair_check, resp_on;
	logic [31:0] lfsr;
	int gen_mode, ready_mode, cycles, error_count, check_count, full_cycles, tb_errors;

	pagerank_arbiter_top pagerank_arbiter_top_inst (.*);

	arbiter_checker arbiter_checker_inst (.*);

	// Taps 32 22 2 1
	function automatic logic lfsr_bit();
		logic fb;
		fb   = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
		lfsr = {lfsr[30:0], fb};
		return fb;
	endfunction

	function automatic logic [31:0] rand_bits(input int n);
		logic [31:0] v;
		v = '0;
		for (int i = 0; i < n; i++) v = {v[30:0], lfsr_bit()};
		return v;
	endfunction

	function automatic logic [`NUM_CU-1:0] thermo_mask(input logic [31:0] count);
		logic [`NUM_CU-1:0] m;
		for (int i = 0; i < `NUM_CU; i++) m[i] = (32'(i) < count);
		return m;
	endfunction

	function automatic logic [`COUNT_BITS-1:0] sum_counts(input logic [`COUNT_BITS-1:0] c [`NUM_CU]);
		logic [`COUNT_BITS-1:0] s;
		s = '0;
		for (int i = 0; i < `NUM_CU; i++) s = s + c[i];
		return s;
	endfunction

	initial begin
		clock = 1'b0;
		forever #2 clock = ~clock;
	end

	always @(posedge clock) accepted <= cu_cmd_valid & cu_cmd_ready;

	// One falling edge of stimulus
	task automatic drive_cycle();
		@(negedge clock);
		for (int i = 0; i < `NUM_CU; i++) begin
			if (!cu_cmd_valid[i] || accepted[i]) begin
				cu_cmd_valid[i] = (gen_mode == 2) || (gen_mode == 1 && cur_mask[i] && lfsr_bit());
				cu_cmd[i].id         = `CU_ID_BITS'(rand_bits(2));
				cu_cmd[i].addr       = rand_bits(32);
				cu_cmd[i].burst_size = 4'(rand_bits(4));
			end
			if (gen_mode != 2 && !cur_mask[i]) cu_cmd_valid[i] = 1'b0;
			cu_vertex_count[i] = `COUNT_BITS'(rand_bits(16));
		end
		counts_sum     = sum_counts(cu_vertex_count);
		mem_cmd_ready  = (ready_mode == 1) || (ready_mode == 2 && lfsr_bit());
		mem_resp_valid = resp_on && lfsr_bit();
		mem_resp.id    = `CU_ID_BITS'(rand_bits(2));
		mem_resp.data  = rand_bits(32);
	endtask

	task automatic apply_config(input logic [31:0] count);
		cu_config = {rand_bits(32), count};
		cur_mask  = thermo_mask(count);
		repeat (4) drive_cycle();
		exp_mask   = cur_mask;
		mask_check = 1'b1;
		drive_cycle();
		mask_check = 1'b0;
	endtask

	task automatic drain();
		gen_mode   = 0;
		ready_mode = 1;
		while (cu_cmd_valid != '0 || mem_cmd_valid) drive_cycle();
	endtask

	initial begin
		cycles = 0;
		while (cycles < RUN_LIMIT) begin
			@(posedge clock);
			cycles++;
		end
		$display("Timeout after %0d cycles, the run did not reach its end", cycles);
		$display("tests failed");
		$finish;
	end

	initial begin
		lfsr = 32'h8069ccd4;
		rstn = 1'b0;
		enabled_in = 1'b0;
		cu_config = '0;
		cu_cmd = '{default: '0};
		cu_cmd_valid = '0;
		mem_cmd_ready = 1'b0;
		mem_resp = '0;
		mem_resp_valid = 1'b0;
		cu_vertex_count = '{default: '0};
		counts_sum = '0;
		{cur_mask, exp_mask, mask_check, fair_check, resp_on} = '0;
		gen_mode = 0;
		ready_mode = 1;
		tb_errors = 0;
		repeat (3) @(negedge clock);
		rstn = 1'b1;
		enabled_in = 1'b1;
		apply_config(32'd4);
		// Random traffic, then a long stall and a random release
		gen_mode = 1;
		ready_mode = 2;
		repeat (DELIVERY) drive_cycle();
		ready_mode = 0;
		repeat (STALL) drive_cycle();
		ready_mode = 2;
		repeat (RELEASE) drive_cycle();
		drain();
		apply_config(32'd2);
		// Every CU requests, disabled ones included
		gen_mode = 2;
		repeat (4) drive_cycle();
		fair_check = 1'b1;
		repeat (FAIR) drive_cycle();
		fair_check = 1'b0;
		drain();
		apply_config(32'd1);
		resp_on = 1'b1;
		gen_mode = 1;
		ready_mode = 2;
		repeat (RESP) drive_cycle();
		resp_on = 1'b0;
		drain();
		repeat (3) drive_cycle();
		if (full_cycles == 0) begin
			$display("Error: the command buffer never filled during the stall");
			tb_errors++;
		end
		$display("checks %0d, errors %0d", check_count, error_count + tb_errors);
		if (error_count + tb_errors == 0) begin
			$display("all tests passed");
		end else begin
			$display("tests failed");
		end
		$finish;
	end

endmodule

`default_nettype wire

// ==== vertex_done_sum.sv ====
// Vertex done summation

`default_nettype none

`include "arbiter_consts.svh"

module vertex_done_sum (
	input  logic                   clock,
	input  logic                   rstn,
	input  logic [`COUNT_BITS-1:0] cu_vertex_count [`NUM_CU],
	output logic [`COUNT_BITS-1:0] vertex_done_total
);

	logic [`COUNT_BITS-1:0] count_q [`NUM_CU];
	logic [`COUNT_BITS-1:0] sum;

	// Stage one, sample the counters
	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			count_q <= '{default: '0};
		end else begin
			count_q <= cu_vertex_count;
		end
	end

	// Wraps at the counter width
	always_comb begin
		sum = '0;
		for (int i = 0; i < `NUM_CU; i++) begin
			sum = sum + count_q[i];
		end
	end

	// Stage two, register the total
	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			vertex_done_total <= '0;
		end else begin
			vertex_done_total <= sum;
		end
	end

endmodule

`default_nettype wire
